/* include/core_defs.svh */
// Text for core_pkg only; relies on opcode_t and alu_func_t being declared before the include
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Major opcodes handled by this core
localparam opcode_t OPC_LUI    = 7'b0110111;
localparam opcode_t OPC_AUIPC  = 7'b0010111;
localparam opcode_t OPC_OP_IMM = 7'b0010011; // ADDI .. SRAI
localparam opcode_t OPC_OP     = 7'b0110011; // ADD .. AND

// funct3 codes, shared by register and immediate forms
localparam alu_func_t F3_ADD  = 3'b000;
localparam alu_func_t F3_SLL  = 3'b001;
localparam alu_func_t F3_SLT  = 3'b010;
localparam alu_func_t F3_SLTU = 3'b011;
localparam alu_func_t F3_XOR  = 3'b100;
localparam alu_func_t F3_SRX  = 3'b101; // SRL and SRA
localparam alu_func_t F3_OR   = 3'b110;
localparam alu_func_t F3_AND  = 3'b111;

`endif

/* design/core_pkg.sv */
// Widths and constants for the RV32I integer core; needs include/ on the include path
package core_pkg;

    typedef logic [31:0] word_t;      // Data, instruction or address
    typedef logic [4:0]  reg_addr_t;
    typedef logic [2:0]  alu_func_t;
    typedef logic [6:0]  opcode_t;

    // Encodings come after the types they use
    `include "core_defs.svh"

    localparam word_t RESET_PC  = 32'h0000_0000;
    localparam word_t INST_STEP = 32'd4;

    localparam int NUM_REGS = 32;
    localparam int SHAMT_W  = 5;

    // Instruction field positions
    localparam int RD_LSB  = 7;
    localparam int F3_LSB  = 12;
    localparam int RS1_LSB = 15;
    localparam int RS2_LSB = 20;
    localparam int IMM_LSB = 20;  // I-type immediate
    localparam int UI_LSB  = 12;  // U-type immediate
    localparam int ALT_BIT = 30;  // SUB / SRA select

endpackage

/* design/fetch_unit.sv */
// Fetch stage; icache_data must belong to icache_addr whenever icache_rdy is high, no redirects
`timescale 1ns/10ps

module fetch_unit (
    input  logic            ctrl_clk,
    input  logic            ctrl_reset,

    output core_pkg::word_t icache_addr,
    input  core_pkg::word_t icache_data,
    input  logic            icache_rdy,

    output core_pkg::word_t fetch_inst,
    output core_pkg::word_t fetch_pc,
    output logic            fetch_valid
);
    import core_pkg::*;

    word_t pc;

    assign icache_addr = pc;

    // Control state
    always_ff @(posedge ctrl_clk) begin
        if (ctrl_reset) begin
            pc          <= RESET_PC;
            fetch_valid <= 1'b0;
        end else if (icache_rdy) begin
            pc          <= pc + INST_STEP;
            fetch_valid <= 1'b1;
        end else begin
            fetch_valid <= 1'b0; // Bubble while the cache is busy
        end
    end

    // Instruction and its own pc
    always_ff @(posedge ctrl_clk) begin
        if (icache_rdy) begin
            fetch_inst <= icache_data;
            fetch_pc   <= pc;
        end
    end

endmodule

/* design/inst_decoder.sv */
// Decodes LUI, AUIPC, OP and OP-IMM only; any other opcode decodes to no register write
`timescale 1ns/10ps

module inst_decoder (
    input  core_pkg::word_t     fetch_inst,

    output core_pkg::reg_addr_t rs1_addr,
    output core_pkg::reg_addr_t rs2_addr,
    output core_pkg::reg_addr_t rd,
    output core_pkg::word_t     imm,
    output core_pkg::alu_func_t alu_func,
    output logic                alu_alt,
    output logic                op1_sel_pc,
    output logic                op1_sel_upper,
    output logic                op2_sel_imm,
    output logic                writes_reg,
    output logic                is_nop
);
    import core_pkg::*;

    localparam int REG_W = $bits(reg_addr_t);

    opcode_t   opcode;
    alu_func_t funct3;
    logic      alt_bit;
    word_t     imm_i;
    word_t     imm_u;

    assign opcode  = fetch_inst[$bits(opcode_t)-1:0];
    assign funct3  = fetch_inst[F3_LSB +: $bits(alu_func_t)];
    assign alt_bit = fetch_inst[ALT_BIT];

    assign rs1_addr = fetch_inst[RS1_LSB +: REG_W];
    assign rs2_addr = fetch_inst[RS2_LSB +: REG_W];
    assign rd       = fetch_inst[RD_LSB +: REG_W];

    assign imm_i = {{20{fetch_inst[31]}}, fetch_inst[31:IMM_LSB]}; // Sign extended
    assign imm_u = {fetch_inst[31:UI_LSB], 12'b0};

    // ADDI x0,x0,0
    assign is_nop = (opcode == OPC_OP_IMM) && (fetch_inst[31:RD_LSB] == '0);

    always_comb begin
        imm           = imm_i;
        alu_func      = funct3;
        alu_alt       = 1'b0;
        op1_sel_pc    = 1'b0;
        op1_sel_upper = 1'b0;
        op2_sel_imm   = 1'b0;
        writes_reg    = 1'b0;
        case (opcode)
            OPC_LUI: begin
                imm           = imm_u;
                alu_func      = F3_ADD;
                op1_sel_upper = 1'b1; // Zero base
                op2_sel_imm   = 1'b1;
                writes_reg    = 1'b1;
            end
            OPC_AUIPC: begin
                imm           = imm_u;
                alu_func      = F3_ADD;
                op1_sel_upper = 1'b1;
                op1_sel_pc    = 1'b1; // pc as base
                op2_sel_imm   = 1'b1;
                writes_reg    = 1'b1;
            end
            OPC_OP_IMM: begin
                // Bit 30 is immediate data except for the shift forms
                alu_alt     = alt_bit && (funct3 == F3_SRX);
                op2_sel_imm = 1'b1;
                writes_reg  = 1'b1;
            end
            OPC_OP: begin
                alu_alt    = alt_bit && ((funct3 == F3_ADD) || (funct3 == F3_SRX));
                writes_reg = 1'b1;
            end
            default: begin
                alu_func = F3_ADD; // Retires silently
            end
        endcase
    end

endmodule

/* design/register_file.sv */
// 32 x 32-bit registers, reads are combinational and see a write only after its edge
`timescale 1ns/10ps

module register_file (
    input  logic                ctrl_clk,

    input  core_pkg::reg_addr_t rs1_addr,
    input  core_pkg::reg_addr_t rs2_addr,
    output core_pkg::word_t     rs1_data,
    output core_pkg::word_t     rs2_data,

    input  logic                wb_en,
    input  core_pkg::reg_addr_t wb_addr,
    input  core_pkg::word_t     wb_data
);
    import core_pkg::*;

    word_t regs [NUM_REGS];

    // x0 reads as zero, its storage is never written
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    always_ff @(posedge ctrl_clk) begin
        if (wb_en && (wb_addr != '0)) begin
            regs[wb_addr] <= wb_data;
        end
    end

endmodule

/* design/operand_stage.sv */
// Decode register; no forwarding, so a source must be written at least three instructions back
`timescale 1ns/10ps

module operand_stage (
    input  logic                ctrl_clk,
    input  logic                ctrl_reset,

    input  logic                fetch_valid,
    input  core_pkg::word_t     fetch_pc,

    input  core_pkg::word_t     imm,
    input  core_pkg::reg_addr_t rd,
    input  core_pkg::alu_func_t alu_func,
    input  logic                alu_alt,
    input  logic                op1_sel_pc,
    input  logic                op1_sel_upper,
    input  logic                op2_sel_imm,
    input  logic                writes_reg,
    input  logic                is_nop,

    input  core_pkg::word_t     rs1_data,
    input  core_pkg::word_t     rs2_data,

    output core_pkg::word_t     op1,
    output core_pkg::word_t     op2,
    output core_pkg::alu_func_t ex_func,
    output logic                ex_alt,
    output core_pkg::reg_addr_t ex_rd,
    output logic                ex_wb,
    output logic                ex_valid
);
    import core_pkg::*;

    word_t op1_next;
    word_t op2_next;

    // Upper-immediate forms add the immediate to pc or zero
    assign op1_next = op1_sel_upper ? (op1_sel_pc ? fetch_pc : '0) : rs1_data;
    assign op2_next = op2_sel_imm ? imm : rs2_data;

    always_ff @(posedge ctrl_clk) begin
        if (ctrl_reset) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= fetch_valid && !is_nop;
        end
    end

    always_ff @(posedge ctrl_clk) begin
        op1     <= op1_next;
        op2     <= op2_next;
        ex_func <= alu_func;
        ex_alt  <= alu_alt;
        ex_rd   <= rd;
        ex_wb   <= writes_reg; // Qualified by ex_valid downstream
    end

endmodule

/* design/alu_stage.sv */
// Execute and writeback; never stalls, wb_en is never raised for x0
`timescale 1ns/10ps

module alu_stage (
    input  logic                ctrl_clk,
    input  logic                ctrl_reset,

    input  core_pkg::word_t     op1,
    input  core_pkg::word_t     op2,
    input  core_pkg::alu_func_t ex_func,
    input  logic                ex_alt,
    input  core_pkg::reg_addr_t ex_rd,
    input  logic                ex_wb,
    input  logic                ex_valid,

    output logic                wb_en,
    output core_pkg::reg_addr_t wb_addr,
    output core_pkg::word_t     wb_data
);
    import core_pkg::*;

    logic [SHAMT_W-1:0] shamt;
    word_t              result;

    assign shamt = op2[SHAMT_W-1:0];

    always_comb begin
        result = '0;
        case (ex_func)
            F3_ADD:  result = ex_alt ? (op1 - op2) : (op1 + op2);
            F3_SLL:  result = op1 << shamt;
            F3_SLT:  result = word_t'($signed(op1) < $signed(op2));
            F3_SLTU: result = word_t'(op1 < op2);
            F3_XOR:  result = op1 ^ op2;
            F3_SRX:  result = ex_alt ? word_t'($signed(op1) >>> shamt) : (op1 >> shamt);
            F3_OR:   result = op1 | op2;
            F3_AND:  result = op1 & op2;
            default: result = '0;
        endcase
    end

    always_ff @(posedge ctrl_clk) begin
        if (ctrl_reset) begin
            wb_en <= 1'b0;
        end else begin
            wb_en <= ex_valid && ex_wb && (ex_rd != '0); // x0 writes dropped here
        end
    end

    always_ff @(posedge ctrl_clk) begin
        wb_addr <= ex_rd;
        wb_data <= result;
    end

endmodule

/* design/core_top.sv */
// RV32I integer core, ALU/LUI/AUIPC only; retire_* mirrors the register-file write port
`timescale 1ns/10ps

module core_top (
    input  logic                ctrl_clk,
    input  logic                ctrl_reset,

    output core_pkg::word_t     icache_addr,
    input  core_pkg::word_t     icache_data,
    input  logic                icache_rdy,

    output logic                retire_en,
    output core_pkg::reg_addr_t retire_rd,
    output core_pkg::word_t     retire_data
);
    import core_pkg::*;

    // Fetch to decode
    word_t     fetch_inst;
    word_t     fetch_pc;
    logic      fetch_valid;

    // Decoder outputs
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    reg_addr_t rd;
    word_t     imm;
    alu_func_t alu_func;
    logic      alu_alt;
    logic      op1_sel_pc;
    logic      op1_sel_upper;
    logic      op2_sel_imm;
    logic      writes_reg;
    logic      is_nop;

    word_t     rs1_data;
    word_t     rs2_data;

    // Operand stage to ALU
    word_t     op1;
    word_t     op2;
    alu_func_t ex_func;
    logic      ex_alt;
    reg_addr_t ex_rd;
    logic      ex_wb;
    logic      ex_valid;

    fetch_unit u_fetch (
        .ctrl_clk    (ctrl_clk),
        .ctrl_reset  (ctrl_reset),
        .icache_addr (icache_addr),
        .icache_data (icache_data),
        .icache_rdy  (icache_rdy),
        .fetch_inst  (fetch_inst),
        .fetch_pc    (fetch_pc),
        .fetch_valid (fetch_valid)
    );

    inst_decoder u_decoder (
        .fetch_inst    (fetch_inst),
        .rs1_addr      (rs1_addr),
        .rs2_addr      (rs2_addr),
        .rd            (rd),
        .imm           (imm),
        .alu_func      (alu_func),
        .alu_alt       (alu_alt),
        .op1_sel_pc    (op1_sel_pc),
        .op1_sel_upper (op1_sel_upper),
        .op2_sel_imm   (op2_sel_imm),
        .writes_reg    (writes_reg),
        .is_nop        (is_nop)
    );

    // Write port is shared with the retire outputs
    register_file u_regs (
        .ctrl_clk (ctrl_clk),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb_en    (retire_en),
        .wb_addr  (retire_rd),
        .wb_data  (retire_data)
    );

    operand_stage u_operand (
        .ctrl_clk      (ctrl_clk),
        .ctrl_reset    (ctrl_reset),
        .fetch_valid   (fetch_valid),
        .fetch_pc      (fetch_pc),
        .imm           (imm),
        .rd            (rd),
        .alu_func      (alu_func),
        .alu_alt       (alu_alt),
        .op1_sel_pc    (op1_sel_pc),
        .op1_sel_upper (op1_sel_upper),
        .op2_sel_imm   (op2_sel_imm),
        .writes_reg    (writes_reg),
        .is_nop        (is_nop),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .op1           (op1),
        .op2           (op2),
        .ex_func       (ex_func),
        .ex_alt        (ex_alt),
        .ex_rd         (ex_rd),
        .ex_wb         (ex_wb),
        .ex_valid      (ex_valid)
    );

    alu_stage u_alu (
        .ctrl_clk   (ctrl_clk),
        .ctrl_reset (ctrl_reset),
        .op1        (op1),
        .op2        (op2),
        .ex_func    (ex_func),
        .ex_alt     (ex_alt),
        .ex_rd      (ex_rd),
        .ex_wb      (ex_wb),
        .ex_valid   (ex_valid),
        .wb_en      (retire_en),
        .wb_addr    (retire_rd),
        .wb_data    (retire_data)
    );

endmodule

/* verif/tb_clock_gen.sv */
// Free-running clock of 20 ns, synchronous reset held high for the first 8 rising edges
`timescale 1ns/10ps

module tb_clock_gen (
    output logic ctrl_clk,
    output logic ctrl_reset
);

    initial begin
        ctrl_clk = 1'b0;
        forever #10 ctrl_clk = ~ctrl_clk;
    end

    initial begin
        ctrl_reset = 1'b1;
        repeat (8) @(posedge ctrl_clk);
        #2 ctrl_reset = 1'b0; // Released just after an edge, like the other inputs
    end

endmodule

/* verif/core_chk.sv */
// Bound into core_top; checks the write port and the fetch port only, no data values
`timescale 1ns/10ps

module core_chk (
    input logic                ctrl_clk,
    input logic                ctrl_reset,
    input core_pkg::word_t     icache_addr,
    input logic                icache_rdy,
    input logic                retire_en,
    input core_pkg::reg_addr_t retire_rd
);
    import core_pkg::*;

    int assert_failures = 0; // Watched by tb_core

    // No retirement ever targets x0
    property no_x0_retire;
        @(posedge ctrl_clk) disable iff (ctrl_reset)
            retire_en |-> (retire_rd != '0);
    endproperty

    // A busy cache freezes the pc
    property pc_holds_when_busy;
        @(posedge ctrl_clk) disable iff (ctrl_reset)
            !icache_rdy |=> $stable(icache_addr);
    endproperty

    // First edge of reset only loads the flop
    property quiet_in_reset;
        @(posedge ctrl_clk)
            (ctrl_reset && $past(ctrl_reset)) |-> !retire_en;
    endproperty

    assert property (no_x0_retire)
        else begin
            $error("retire_en raised with retire_rd zero");
            assert_failures++;
        end
    assert property (pc_holds_when_busy)
        else begin
            $error("icache_addr moved while icache_rdy was low");
            assert_failures++;
        end
    assert property (quiet_in_reset)
        else begin
            $error("retire_en high during reset");
            assert_failures++;
        end

endmodule

/* verif/tb_core.sv */
// Random 200-word ALU program with cache gaps; assumes pc starts at zero and no forwarding
`timescale 1ns/10ps

module tb_core;

    localparam int PROG_LEN  = 200;
    localparam int LIMIT     = 4 * PROG_LEN + 50;
    localparam logic [31:0] NOP_WORD = 32'h0000_0013;

    logic        ctrl_clk;
    logic        ctrl_reset;
    logic [31:0] icache_addr;
    logic [31:0] icache_data;
    logic        icache_rdy;
    logic        retire_en;
    logic [4:0]  retire_rd;
    logic [31:0] retire_data;

    logic [31:0] prog [PROG_LEN];
    logic [31:0] model_regs [32];
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_data [$];
    logic [31:0] rng_state = 32'd24268;
    int          expected_total = 0;
    int          retire_count = 0;
    int          cycles = 0;

    tb_clock_gen clk0 (.ctrl_clk(ctrl_clk), .ctrl_reset(ctrl_reset));

    core_top dut0 (.*);

    bind core_top core_chk chk0 (.*);

    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1);
    endtask

    // RV32I ALU semantics
    function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // Source picked away from the last two destinations
    function automatic logic [4:0] pick_src(input logic [4:0] d1, input logic [4:0] d2);
        logic [4:0] r;
        r = 5'(next_rand() % 32);
        while (r == d1 || r == d2) r = 5'(next_rand() % 32);
        return r;
    endfunction

    task automatic build_program();
        logic [4:0]  d1;
        logic [4:0]  d2;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  bad_opc [6];
        logic [31:0] r;
        bad_opc = '{7'b0000011, 7'b0100011, 7'b1100011, 7'b1101111, 7'b1110011, 7'b0001111};
        // Prologue gives x1..x31 a defined value before any read
        for (int i = 0; i < 31; i++) begin
            r = next_rand();
            prog[i] = {r[31:20], 5'd0, 3'd0, 5'(i + 1), 7'b0010011};
        end
        d1 = 5'd31;
        d2 = 5'd30;
        for (int i = 31; i < PROG_LEN; i++) begin
            rd  = 5'(next_rand() % 32);
            rs1 = pick_src(d1, d2);
            rs2 = pick_src(d1, d2);
            f3  = 3'(next_rand() % 8);
            r   = next_rand();
            case (next_rand() % 16)
                0, 1, 2, 3, 4:  // OP, bit 30 random for every funct3
                    prog[i] = {1'b0, r[0], 5'b0, rs2, rs1, f3, rd, 7'b0110011};
                5, 6, 7, 8, 9:
                    if (f3 == 3'd1 || f3 == 3'd5)
                        prog[i] = {1'b0, r[0] & f3[2], 5'b0, r[8:4], rs1, f3, rd, 7'b0010011};
                    else
                        prog[i] = {r[31:20], rs1, f3, rd, 7'b0010011};
                10:      prog[i] = {r[31:12], rd, 7'b0110111};
                11:      prog[i] = {r[31:12], rd, 7'b0010111};
                12:      prog[i] = NOP_WORD;
                13:      prog[i] = {r[31:7], bad_opc[r[2:0] % 6]};
                14:      prog[i] = {r[31:20], rs1, 3'd0, 5'd0, 7'b0010011}; // x0 target
                // ADDI with immediate bit 10, the SUB select of the register form
                default: prog[i] = {r[31], 1'b1, r[29:20], rs1, 3'd0, rd, 7'b0010011};
            endcase
            d2 = d1;
            d1 = prog[i][11:7];
        end
    endtask

    // In-order execution of the whole image, queueing each register write
    task automatic run_model();
        logic [31:0] inst;
        logic [31:0] a;
        logic [31:0] val;
        logic        wr;
        for (int k = 0; k < 32; k++) model_regs[k] = '0;
        for (int i = 0; i < PROG_LEN; i++) begin
            inst = prog[i];
            a    = model_regs[inst[19:15]];
            wr   = 1'b1;
            case (inst[6:0])
                7'b0110111: val = {inst[31:12], 12'b0};
                7'b0010111: val = 32'(i * 4) + {inst[31:12], 12'b0};
                7'b0010011: val = ref_alu(inst[14:12], inst[14:12] == 3'd5 && inst[30], a,
                                          {{20{inst[31]}}, inst[31:20]});
                7'b0110011: val = ref_alu(inst[14:12],
                                          (inst[14:12] == 3'd0 || inst[14:12] == 3'd5) && inst[30],
                                          a, model_regs[inst[24:20]]);
                default:    wr = 1'b0;
            endcase
            if (wr && inst[11:7] != 5'd0) begin
                model_regs[inst[11:7]] = val;
                exp_rd.push_back(inst[11:7]);
                exp_data.push_back(val);
            end
        end
        expected_total = exp_rd.size();
    endtask

    initial begin
        icache_rdy  = 1'b0;
        icache_data = '0;
    end

    // Cache model, busy about one cycle in four
    always @(posedge ctrl_clk) begin
        #2;
        icache_rdy  = (next_rand() % 4) != 0;
        icache_data = (icache_addr[31:2] < PROG_LEN) ? prog[icache_addr[31:2]] : NOP_WORD;
    end

    always @(posedge ctrl_clk) if (!ctrl_reset) cycles++;

    // Compare each retirement at the falling edge, where outputs are settled
    always @(negedge ctrl_clk) begin
        assert (dut0.chk0.assert_failures == 0)
            else report_failure("a concurrent assertion bound into core_top failed");
        if (!ctrl_reset && retire_en === 1'b1) begin
            assert (exp_rd.size() > 0)
                else report_failure("a retirement arrived that the program never produced");
            assert (retire_rd == exp_rd[0])
                else begin
                    $display("[ERROR] %0t ns: retire_rd got %0d expected %0d",
                             $time, retire_rd, exp_rd[0]);
                    report_failure("retirement out of order or lost");
                end
            assert (retire_data == exp_data[0])
                else begin
                    $display("[ERROR] %0t ns: retire_data got %h expected %h",
                             $time, retire_data, exp_data[0]);
                    report_failure($sformatf("wrong result for x%0d", retire_rd));
                end
            void'(exp_rd.pop_front());
            void'(exp_data.pop_front());
            retire_count++;
        end
    end

    initial begin
        build_program();
        run_model();
        wait (!ctrl_reset);
        while (retire_count < expected_total && cycles < LIMIT) @(posedge ctrl_clk);
        repeat (10) @(posedge ctrl_clk); // Catch any extra retirement
        if (retire_count == expected_total && exp_rd.size() == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("run timed out after %0d cycles with %0d of %0d retirements",
                     cycles, retire_count, expected_total);
            $display("tests failed");
            $fatal(1);
        end
    end

endmodule

/* sources.f */
+incdir+include
design/core_pkg.sv
design/fetch_unit.sv
design/inst_decoder.sv
design/register_file.sv
design/operand_stage.sv
design/alu_stage.sv
design/core_top.sv
verif/tb_clock_gen.sv
verif/core_chk.sv
verif/tb_core.sv

/* Bender.yml */
package:
  name: rv32i_int_core

sources:
  - include_dirs:
      - include
    files:
      - design/core_pkg.sv
      - design/fetch_unit.sv
      - design/inst_decoder.sv
      - design/register_file.sv
      - design/operand_stage.sv
      - design/alu_stage.sv
      - design/core_top.sv
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/core_chk.sv
      - verif/tb_core.sv
